/* mgt_mul.f */
verilog/mul_pkg.sv
verilog/booth_if.sv
verilog/booth_radix4_core.sv
verilog/mul_req_ctrl.sv
verilog/mul_unit_top.sv
bench/mul_unit_assertions.sv
bench/mul_unit_checker.sv
bench/mul_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the multiply unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module mul_unit_tb -f mgt_mul.f -o mul_unit_sim

# Error limit raised so every assertion failure is counted and the run ends normally
out=$(./obj_dir/mul_unit_sim +verilator+error+limit+1000) || true
echo "$out"

# Pass only when the testbench printed its pass line
if echo "$out" | grep -q "^RESULT: PASS$"; then
  exit 0
fi
exit 1

/* bench/mul_unit_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module mul_unit_tb;
  import mul_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int DRIVE_DLY  = 2;   // Input drive point after posedge
  localparam int RESET_CYC  = 8;
  localparam int TIMEOUT    = 100; // Cycles per wait
  localparam int NUM_ROWS   = 27;
  localparam int NUM_RAND   = 40;
  localparam int SEED       = 91029;

  // One request with its expected result
  typedef struct packed {
    mul_op_e op;
    word_t   mcand;
    word_t   mplier;
    word_t   exp;
  } row_t;

  logic    clk_i = 1'b0;
  logic    rst_n_i;
  logic    req_i;
  mul_op_e op_i;
  word_t   multiplicand_i;
  word_t   multiplier_i;
  logic    ack_o;
  word_t   result_o;

  logic  exp_valid;   // Table row in flight
  word_t exp_result;

  int   mismatch_cnt;
  int   proto_err_cnt;
  int   checked_cnt;
  int   timeout_cnt   = 0;
  int   other_err_cnt = 0;
  int   issued_cnt    = 0;
  int   assert_cnt    = 0;
  bit   aborted       = 1'b0;  // Set on timeout
  row_t rows [NUM_ROWS];

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  mul_unit_top mul_unit_top_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_i          (req_i),
    .op_i           (op_i),
    .multiplicand_i (multiplicand_i),
    .multiplier_i   (multiplier_i),
    .ack_o          (ack_o),
    .result_o       (result_o)
  );

  mul_unit_checker mul_unit_checker_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .req_i           (req_i),
    .op_i            (op_i),
    .multiplicand_i  (multiplicand_i),
    .multiplier_i    (multiplier_i),
    .ack_i           (ack_o),
    .result_i        (result_o),
    .exp_valid_i     (exp_valid),
    .exp_result_i    (exp_result),
    .mismatch_cnt_o  (mismatch_cnt),
    .proto_err_cnt_o (proto_err_cnt),
    .checked_cnt_o   (checked_cnt)
  );

  bind mul_unit_top mul_unit_assertions mul_unit_assertions_i (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (req_i),
    .ack_i    (ack_o),
    .result_i (result_o)
  );

  ////////////////////////////////////////
  // Stimulus table, signed 64-bit product
  ////////////////////////////////////////

  task automatic load_table();
    rows = '{
      '{MUL_LO, 32'h00000000, 32'h00000000, 32'h00000000},  // Zeros
      '{MUL_LO, 32'h00000001, 32'h00000001, 32'h00000001},
      '{MUL_LO, 32'hFFFFFFFF, 32'h00000001, 32'hFFFFFFFF},  // -1 * 1
      '{MUL_LO, 32'h00000007, 32'hFFFFFFFD, 32'hFFFFFFEB},  // 7 * -3
      '{MUL_LO, 32'hFFFFFFF4, 32'hFFFFFFF5, 32'h00000084},  // -12 * -11
      '{MUL_LO, 32'h0000FFFF, 32'h0000FFFF, 32'hFFFE0001},  // Run of ones
      '{MUL_LO, 32'h00000003, 32'h55555555, 32'hFFFFFFFF},  // Alternating bits
      '{MUL_LO, 32'h00000002, 32'hAAAAAAAA, 32'h55555554},
      '{MUL_LO, 32'h12345678, 32'hFFFFFFFF, 32'hEDCBA988},
      '{MUL_LO, 32'h12345678, 32'h00000010, 32'h23456780},
      '{MUL_HI, 32'hFFFFFFFF, 32'h00000001, 32'hFFFFFFFF},  // Sign extension
      '{MUL_HI, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'h00000000},
      '{MUL_HI, 32'h00000007, 32'hFFFFFFFD, 32'hFFFFFFFF},
      '{MUL_HI, 32'hFFFFFFF4, 32'hFFFFFFF5, 32'h00000000},
      '{MUL_HI, 32'h0000FFFF, 32'h0000FFFF, 32'h00000000},
      '{MUL_HI, 32'h00000002, 32'hAAAAAAAA, 32'hFFFFFFFF},
      '{MUL_HI, 32'h12345678, 32'hFFFFFFFF, 32'hFFFFFFFF},
      '{MUL_HI, 32'h12345678, 32'h00000010, 32'h00000001},
      '{MUL_HI, 32'h7FFF0000, 32'h00010000, 32'h00007FFF},
      '{MUL_LO, 32'h80000000, 32'h80000000, 32'h00000000},  // Min * min
      '{MUL_HI, 32'h80000000, 32'h80000000, 32'h40000000},
      '{MUL_LO, 32'h80000000, 32'h7FFFFFFF, 32'h80000000},  // Min * max
      '{MUL_HI, 32'h80000000, 32'h7FFFFFFF, 32'hC0000000},
      '{MUL_LO, 32'h7FFFFFFF, 32'h7FFFFFFF, 32'h00000001},  // Max squared
      '{MUL_HI, 32'h7FFFFFFF, 32'h7FFFFFFF, 32'h3FFFFFFF},
      '{MUL_LO, 32'hFFFFFFFF, 32'h55555555, 32'hAAAAAAAB},
      '{MUL_HI, 32'hFFFFFFFF, 32'h55555555, 32'hFFFFFFFF}
    };
  endtask

  // Next drive point
  task automatic next_cycle();
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  // Bounded wait for ack_o to reach a level
  task automatic wait_ack(input logic level);
    int cnt;
    cnt = 0;
    while (ack_o !== level && cnt < TIMEOUT)
    begin
      next_cycle();
      cnt++;
    end
    if (ack_o !== level)
    begin
      timeout_cnt++;
      aborted = 1'b1;
      $display("Timeout at %0t: ack_o did not reach %0d within %0d cycles",
               $time, level, TIMEOUT);
    end
  endtask

  // Full four-phase transfer with random back-pressure
  task automatic run_request(input row_t row, input logic use_exp);
    int hold;
    op_i           = row.op;
    multiplicand_i = row.mcand;
    multiplier_i   = row.mplier;
    exp_valid      = use_exp;
    exp_result     = row.exp;
    req_i          = 1'b1;
    issued_cnt++;
    wait_ack(1'b1);
    if (!aborted)
    begin
      hold = $urandom_range(10, 0);  // Requester holds req after ack
      repeat (hold) next_cycle();
      req_i = 1'b0;
      wait_ack(1'b0);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial
  begin
    row_t row;
    void'($urandom(SEED));
    load_table();
    rst_n_i        = 1'b0;
    req_i          = 1'b0;
    op_i           = MUL_LO;
    multiplicand_i = '0;
    multiplier_i   = '0;
    exp_valid      = 1'b0;
    exp_result     = '0;

    repeat (RESET_CYC) @(posedge clk_i);
    #DRIVE_DLY;
    rst_n_i = 1'b1;
    repeat (5) next_cycle();  // Idle, ack_o must stay low

    for (int i = 0; i < NUM_ROWS && !aborted; i++)
      run_request(rows[i], 1'b1);

    for (int i = 0; i < NUM_RAND && !aborted; i++)
    begin
      row.op     = mul_op_e'($urandom_range(1, 0));
      row.mcand  = $urandom();
      row.mplier = $urandom();
      row.exp    = '0;  // Checker derives it
      run_request(row, 1'b0);
    end

    next_cycle();
    assert_cnt = mul_unit_top_i.mul_unit_assertions_i.fail_cnt;
    if (!aborted && checked_cnt != issued_cnt)
    begin
      other_err_cnt++;
      $display("Checker saw %0d results for %0d requests", checked_cnt, issued_cnt);
    end

    $display("Errors: mismatch %0d, handshake %0d, timeout %0d, assertion %0d, other %0d",
             mismatch_cnt, proto_err_cnt, timeout_cnt, assert_cnt, other_err_cnt);
    if (mismatch_cnt + proto_err_cnt + timeout_cnt + assert_cnt + other_err_cnt == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/mul_unit_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module mul_unit_checker (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             req_i,
  input  mul_pkg::mul_op_e op_i,
  input  mul_pkg::word_t   multiplicand_i,
  input  mul_pkg::word_t   multiplier_i,
  input  logic             ack_i,           // DUT ack_o
  input  mul_pkg::word_t   result_i,        // DUT result_o
  input  logic             exp_valid_i,     // Table row in flight
  input  mul_pkg::word_t   exp_result_i,    // Table value for that row
  output int               mismatch_cnt_o,
  output int               proto_err_cnt_o,
  output int               checked_cnt_o
);
  import mul_pkg::*;

  logic  ack_q    = 1'b0;  // Values seen at the previous edge
  logic  req_q    = 1'b0;
  logic  rst_n_q  = 1'b1;
  word_t result_q = '0;

  int mismatch_cnt  = 0;
  int proto_err_cnt = 0;
  int checked_cnt   = 0;

  // Signed 64-bit product, op picks the half
  function automatic word_t product_half(mul_op_e op, word_t a, word_t b);
    logic signed [63:0] prod;
    prod = longint'(a) * longint'(b);
    if (op == MUL_HI)
      return prod[63:32];
    return prod[31:0];
  endfunction

  ////////////////////////////////////////
  // Port watch, pre-edge values
  ////////////////////////////////////////

  always @(posedge clk_i)
  begin
    word_t exp;
    exp = product_half(op_i, multiplicand_i, multiplier_i);  // Inputs held while req high

    if (!rst_n_q && ack_i)
    begin
      proto_err_cnt++;
      $display("Handshake error at %0t: ack_o high during reset", $time);
    end

    if (ack_i && !ack_q)  // Rising ack
    begin
      checked_cnt++;
      if (!req_q)
      begin
        proto_err_cnt++;
        $display("Handshake error at %0t: ack_o rose without a request", $time);
      end
      if (result_i !== exp)
      begin
        mismatch_cnt++;
        $display("Mismatch at %0t: result_o expected %h, got %h (%s %h * %h)",
                 $time, exp, result_i, op_i.name(), multiplicand_i, multiplier_i);
      end
      if (exp_valid_i && result_i !== exp_result_i)
      begin
        mismatch_cnt++;
        $display("Mismatch at %0t: result_o table value %h, got %h",
                 $time, exp_result_i, result_i);
      end
    end

    if (ack_i && ack_q && result_i !== result_q)  // Back-pressure hold
    begin
      mismatch_cnt++;
      $display("Mismatch at %0t: result_o held %h, got %h while ack_o high",
               $time, result_q, result_i);
    end

    if (!ack_i && ack_q && req_q)
    begin
      proto_err_cnt++;
      $display("Handshake error at %0t: ack_o dropped while req_i still high", $time);
    end

    ack_q    <= ack_i;
    req_q    <= req_i;
    rst_n_q  <= rst_n_i;
    result_q <= result_i;
  end

  assign mismatch_cnt_o  = mismatch_cnt;
  assign proto_err_cnt_o = proto_err_cnt;
  assign checked_cnt_o   = checked_cnt;

endmodule

`default_nettype wire

/* bench/mul_unit_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module mul_unit_assertions (
  input logic           clk_i,
  input logic           rst_n_i,
  input logic           req_i,
  input logic           ack_i,     // DUT ack_o
  input mul_pkg::word_t result_i   // DUT result_o
);

  int fail_cnt = 0;  // Failed assertion count

  // Rise follows the edge that still saw req high
  ack_rise_needs_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) $rose(ack_i) |-> $past(req_i))
  else
  begin
    fail_cnt++;
    $error("ack_o rose with no request pending");
  end

  // Phase four only after req low
  ack_fall_after_req_low: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) $fell(ack_i) |-> !$past(req_i))
  else
  begin
    fail_cnt++;
    $error("ack_o fell while req_i was still high");
  end

  // Result frozen for the whole ack phase
  result_stable_in_ack: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) (ack_i && $past(ack_i)) |-> $stable(result_i))
  else
  begin
    fail_cnt++;
    $error("result_o changed while ack_o was high");
  end

endmodule

`default_nettype wire

/* verilog/mul_unit_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mul_unit_top (
  input  logic             clk_i,
  input  logic             rst_n_i,         // Sync reset, active low
  input  logic             req_i,           // Four-phase request
  input  mul_pkg::mul_op_e op_i,            // MUL_LO or MUL_HI
  input  mul_pkg::word_t   multiplicand_i,
  input  mul_pkg::word_t   multiplier_i,
  output logic             ack_o,           // Result valid, held until req_i low
  output mul_pkg::word_t   result_o         // Selected half of signed product
);

  ////////////////////////////////////////
  // Controller to core link
  ////////////////////////////////////////

  booth_if booth_bus (
    .clk_i (clk_i)
  );

  // Handshake, capture, half select
  mul_req_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_i          (req_i),
    .op_i           (op_i),
    .multiplicand_i (multiplicand_i),
    .multiplier_i   (multiplier_i),
    .ack_o          (ack_o),
    .result_o       (result_o),
    .bus            (booth_bus.ctrl)
  );

  // Iterative multiplier, 16 steps
  booth_radix4_core u_core (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus     (booth_bus.core)
  );

endmodule

`default_nettype wire

/* verilog/mul_req_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module mul_req_ctrl (
  input  logic             clk_i,
  input  logic             rst_n_i,         // Sync reset, active low
  input  logic             req_i,           // Four-phase request
  input  mul_pkg::mul_op_e op_i,            // Which product half
  input  mul_pkg::word_t   multiplicand_i,  // Stable while req_i high
  input  mul_pkg::word_t   multiplier_i,
  output logic             ack_o,           // Result valid
  output mul_pkg::word_t   result_o,
  booth_if.ctrl            bus              // To Booth core
);
  import mul_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  logic    accept;    // Request taken this edge
  logic    start_q;   // Start pulse to core
  mul_op_e op_q;      // Captured op
  word_t   mcand_q;   // Captured operands
  word_t   mplier_q;
  word_t   result_q;  // Selected product half

  ////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////

  assign accept = (state_q == IDLE) && req_i;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
      begin
        if (req_i)
          state_d = RUN;
      end
      RUN:
      begin
        if (bus.done)
          state_d = ACK;  // Result lands same edge
      end
      ACK:
      begin
        if (!req_i)
          state_d = IDLE;  // Phase four, drop ack
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= IDLE;
      start_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      start_q <= accept;  // One cycle, core is idle in IDLE
    end
  end

  ////////////////////////////////////////
  // Operand capture and result select
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      op_q     <= op_i;
      mcand_q  <= multiplicand_i;
      mplier_q <= multiplier_i;
    end

    // Halves are stable on done, take the one asked for
    if ((state_q == RUN) && bus.done)
    begin
      if (op_q == MUL_HI)
        result_q <= bus.product_hi;
      else
        result_q <= bus.product_lo;
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  assign ack_o    = (state_q == ACK);  // Held until req_i seen low
  assign result_o = result_q;

  assign bus.start        = start_q;
  assign bus.multiplicand = mcand_q;  // Stable through whole run
  assign bus.multiplier   = mplier_q;

endmodule

`default_nettype wire

/* verilog/booth_radix4_core.sv */
`timescale 1ns/10ps
`default_nettype none

module booth_radix4_core (
  input  logic  clk_i,    // Core clock
  input  logic  rst_n_i,  // Sync reset, active low
  booth_if.core bus       // Operands in, product out
);
  import mul_pkg::*;

  // Whole shift register, shifted as one vector
  typedef struct packed {
    pprod_t part;    // Running partial product
    word_t  mplier;  // Multiplier, consumed two bits per step
    logic   last;    // Last bit shifted out
  } acc_t;

  acc_t   acc_q;
  acc_t   acc_d;
  pprod_t mcand_q;  // Sign-extended multiplicand

  // Two extra bits so +/- 2x never wraps before the shift
  logic signed [XLEN+2:0] mcand_ext;
  logic signed [XLEN+2:0] part_ext;
  logic signed [XLEN+2:0] sum;  // Partial product after add/sub

  logic                  busy_q;      // Iterating
  logic [STEP_CNT_W-1:0] step_cnt_q;  // Steps done so far
  logic                  done_q;      // Registered done pulse
  logic                  last_step;

  ////////////////////////////////////////
  // Step control
  ////////////////////////////////////////

  assign last_step = (step_cnt_q == STEP_CNT_W'(BOOTH_STEPS - 1));

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      busy_q     <= 1'b0;
      step_cnt_q <= '0;
      done_q     <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;  // Low unless last step
      if (bus.start)
      begin
        busy_q     <= 1'b1;  // Load edge, first step next edge
        step_cnt_q <= '0;
      end
      else if (busy_q)
      begin
        step_cnt_q <= step_cnt_q + 1'b1;
        if (last_step)
        begin
          busy_q <= 1'b0;  // Freeze result
          done_q <= 1'b1;  // High the cycle after step 16
        end
      end
    end
  end

  ////////////////////////////////////////
  // Datapath registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (bus.start)
    begin
      acc_q   <= '{part: '0, mplier: bus.multiplier, last: 1'b0};
      mcand_q <= {bus.multiplicand[XLEN-1], bus.multiplicand};  // Sign extend
    end
    else if (busy_q)
      acc_q <= acc_d;  // One radix-4 step
  end

  ////////////////////////////////////////
  // Booth radix-4 step
  ////////////////////////////////////////

  always_comb
  begin
    mcand_ext = {{2{mcand_q[XLEN]}}, mcand_q};
    part_ext  = {{2{acc_q.part[XLEN]}}, acc_q.part};

    // Digit from low two multiplier bits plus last shifted bit
    case ({acc_q.mplier[1:0], acc_q.last})
      3'b001:  sum = part_ext + mcand_ext;           // +1x
      3'b010:  sum = part_ext + mcand_ext;           // +1x
      3'b011:  sum = part_ext + (mcand_ext <<< 1);   // +2x
      3'b100:  sum = part_ext - (mcand_ext <<< 1);   // -2x
      3'b101:  sum = part_ext - mcand_ext;           // -1x
      3'b110:  sum = part_ext - mcand_ext;           // -1x
      default: sum = part_ext;                       // 000 and 111, zero
    endcase

    // Arithmetic shift right by two over the whole register
    acc_d.part   = sum[XLEN+2:2];
    acc_d.mplier = {sum[1:0], acc_q.mplier[XLEN-1:2]};
    acc_d.last   = acc_q.mplier[1];
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  assign bus.done       = done_q;
  assign bus.product_hi = acc_q.part[XLEN-1:0];  // Product bits 63..32
  assign bus.product_lo = acc_q.mplier;          // Product bits 31..0

endmodule

`default_nettype wire

/* verilog/booth_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface booth_if (
  input logic clk_i  // Shared clock
);
  import mul_pkg::*;

  logic  start;         // One-cycle pulse, core idle only
  word_t multiplicand;  // Valid with start
  word_t multiplier;    // Valid with start
  logic  done;          // One-cycle pulse after last step
  word_t product_hi;    // Stable from done until next start
  word_t product_lo;

  // Controller side
  modport ctrl (
    input  clk_i,
    output start,
    output multiplicand,
    output multiplier,
    input  done,
    input  product_hi,
    input  product_lo
  );

  // Booth core side
  modport core (
    input  clk_i,
    input  start,
    input  multiplicand,
    input  multiplier,
    output done,
    output product_hi,
    output product_lo
  );

endinterface

`default_nettype wire

/* verilog/mul_pkg.sv */
`default_nettype none

package mul_pkg;

  ////////////////////////////////////////
  // Widths and step count
  ////////////////////////////////////////

  localparam int XLEN        = 32;        // Operand width
  localparam int BOOTH_STEPS = XLEN / 2;  // Two multiplier bits per step
  localparam int STEP_CNT_W  = 5;         // Step counter width

  ////////////////////////////////////////
  // Word types
  ////////////////////////////////////////

  typedef logic signed [XLEN-1:0] word_t;   // Operands, product halves
  typedef logic signed [XLEN:0]   pprod_t;  // Partial product, one guard bit

  ////////////////////////////////////////
  // Enums
  ////////////////////////////////////////

  typedef enum logic {
    MUL_LO = 1'b0,  // Product bits 31..0
    MUL_HI = 1'b1   // Product bits 63..32
  } mul_op_e;

  // Request controller states
  typedef enum logic [1:0] {
    IDLE = 2'd0,  // Waiting for req
    RUN  = 2'd1,  // Core busy
    ACK  = 2'd2   // Result out, waiting for req low
  } ctrl_state_e;

endpackage

`default_nettype wire
